//--- rtl/mips_pkg.sv
package mips_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;
    localparam logic [word_w-1:0] reset_pc = 32'h0000_0000;
    localparam logic [word_w-1:0] pc_step  = 32'h0000_0004;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // primary opcodes, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_addiu   = 6'b001001,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_sw      = 6'b101011
    } opcode_e;

    // special function codes, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'b000000,
        fn_srl  = 6'b000010,
        fn_addu = 6'b100001,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110
    } funct_e;

    typedef enum logic [3:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_lui,
        alu_store
    } alu_op_e;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     operand_a;
        word_t     operand_b;
        word_t     store_data;
        logic      wreg;
        reg_addr_t waddr;
    } id_ex_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        logic      is_store;
        word_t     mem_addr;
        word_t     store_data;
    } ex_mem_t;

    // register write, also used as a forwarding source
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  word_t rom_data_i,
    output word_t rom_addr_o,
    output logic  rom_ce_o,
    output word_t inst_o
);

    // pc holds reset_pc through the first enabled cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rom_ce_o   <= 1'b0;
            rom_addr_o <= reset_pc;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o) begin
                rom_addr_o <= rom_addr_o + pc_step;
            end
        end
    end

    // fetch/decode register, all zeros is sll r0 which decodes as a no-op
    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_o <= '0;
        end else begin
            inst_o <= rom_ce_o ? rom_data_i : '0;
        end
    end

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  wb_t       wb_i
);

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (!reset_i && wb_i.we && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // r0 reads zero, same-cycle write passes through
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else if (wb_i.we && wb_i.waddr == raddr1_i) begin
            rdata1_o = wb_i.wdata;
        end else begin
            rdata1_o = regs[raddr1_i];
        end

        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else if (wb_i.we && wb_i.waddr == raddr2_i) begin
            rdata2_o = wb_i.wdata;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

    // decode drops wreg for rd == 0, so no write to r0 ever reaches write-back
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
        wb_i.we |-> wb_i.waddr != '0);

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  word_t     inst_i,
    input  word_t     rdata1_i,
    input  word_t     rdata2_i,
    output reg_addr_t raddr1_o,
    output reg_addr_t raddr2_o,
    input  wb_t       ex_fwd_i,
    input  wb_t       mem_fwd_i,
    output id_ex_t    id_ex_o
);

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    word_t     imm_zext;
    word_t     imm_sext;
    word_t     shamt_zext;
    word_t     rs_val;
    word_t     rt_val;
    id_ex_t    id_ex_d;

    // newest producer wins: execute, then memory, then the register file
    function automatic word_t fwd_select(reg_addr_t addr, word_t rf_data,
                                         wb_t ex_src, wb_t mem_src);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_src.we && ex_src.waddr == addr) begin
            value = ex_src.wdata;
        end else if (mem_src.we && mem_src.waddr == addr) begin
            value = mem_src.wdata;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign opcode = opcode_e'(inst_i[31:26]);
    assign funct  = funct_e'(inst_i[5:0]);
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign imm    = inst_i[15:0];

    assign imm_zext   = {{(word_w-16){1'b0}}, imm};
    assign imm_sext   = {{(word_w-16){imm[15]}}, imm};
    assign shamt_zext = {{(word_w-5){1'b0}}, shamt};

    assign raddr1_o = rs;
    assign raddr2_o = rt;

    assign rs_val = fwd_select(rs, rdata1_i, ex_fwd_i, mem_fwd_i);
    assign rt_val = fwd_select(rt, rdata2_i, ex_fwd_i, mem_fwd_i);

    always_comb begin
        id_ex_d.alu_op     = alu_nop;
        id_ex_d.operand_a  = rs_val;
        id_ex_d.operand_b  = rt_val;
        id_ex_d.store_data = rt_val;
        id_ex_d.wreg       = 1'b0;
        id_ex_d.waddr      = rd;

        case (opcode)
            op_special: begin
                id_ex_d.wreg = 1'b1;
                case (funct)
                    fn_sll: begin
                        id_ex_d.alu_op    = alu_sll;
                        id_ex_d.operand_a = rt_val;
                        id_ex_d.operand_b = shamt_zext;
                    end
                    fn_srl: begin
                        id_ex_d.alu_op    = alu_srl;
                        id_ex_d.operand_a = rt_val;
                        id_ex_d.operand_b = shamt_zext;
                    end
                    fn_addu: id_ex_d.alu_op = alu_add;
                    fn_subu: id_ex_d.alu_op = alu_sub;
                    fn_and:  id_ex_d.alu_op = alu_and;
                    fn_or:   id_ex_d.alu_op = alu_or;
                    fn_xor:  id_ex_d.alu_op = alu_xor;
                    default: id_ex_d.wreg = 1'b0;
                endcase
            end
            op_addiu: begin
                id_ex_d.alu_op    = alu_add;
                id_ex_d.operand_b = imm_sext;
            end
            op_andi: begin
                id_ex_d.alu_op    = alu_and;
                id_ex_d.operand_b = imm_zext;
            end
            op_ori: begin
                id_ex_d.alu_op    = alu_or;
                id_ex_d.operand_b = imm_zext;
            end
            op_xori: begin
                id_ex_d.alu_op    = alu_xor;
                id_ex_d.operand_b = imm_zext;
            end
            op_lui: begin
                id_ex_d.alu_op    = alu_lui;
                id_ex_d.operand_b = imm_zext;
            end
            op_sw: begin
                id_ex_d.alu_op    = alu_store;
                id_ex_d.operand_b = imm_sext;
            end
            default: ;
        endcase

        // i-type results go to rt
        if (opcode != op_special && opcode != op_sw && id_ex_d.alu_op != alu_nop) begin
            id_ex_d.wreg  = 1'b1;
            id_ex_d.waddr = rt;
        end

        // r0 writes are dropped here
        if (id_ex_d.waddr == '0) begin
            id_ex_d.wreg = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_o.alu_op <= alu_nop;
            id_ex_o.wreg   <= 1'b0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

    // an X instruction would decode silently as a no-op
    a_inst_known: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown(inst_i));

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  id_ex_t  id_ex_i,
    output wb_t     ex_fwd_o,
    output ex_mem_t ex_mem_o
);

    word_t   result;
    word_t   mem_addr;
    ex_mem_t ex_mem_d;

    always_comb begin
        case (id_ex_i.alu_op)
            alu_add: result = id_ex_i.operand_a + id_ex_i.operand_b;
            alu_sub: result = id_ex_i.operand_a - id_ex_i.operand_b;
            alu_and: result = id_ex_i.operand_a & id_ex_i.operand_b;
            alu_or:  result = id_ex_i.operand_a | id_ex_i.operand_b;
            alu_xor: result = id_ex_i.operand_a ^ id_ex_i.operand_b;
            alu_sll: result = id_ex_i.operand_a << id_ex_i.operand_b[4:0];
            alu_srl: result = id_ex_i.operand_a >> id_ex_i.operand_b[4:0];
            alu_lui: result = {id_ex_i.operand_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // base plus sign-extended offset
    assign mem_addr = id_ex_i.operand_a + id_ex_i.operand_b;

    assign ex_fwd_o.we    = id_ex_i.wreg;
    assign ex_fwd_o.waddr = id_ex_i.waddr;
    assign ex_fwd_o.wdata = result;

    always_comb begin
        ex_mem_d.wreg       = id_ex_i.wreg;
        ex_mem_d.waddr      = id_ex_i.waddr;
        ex_mem_d.wdata      = result;
        ex_mem_d.is_store   = (id_ex_i.alu_op == alu_store);
        ex_mem_d.mem_addr   = mem_addr;
        ex_mem_d.store_data = id_ex_i.store_data;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_mem_o.wreg     <= 1'b0;
            ex_mem_o.is_store <= 1'b0;
        end else begin
            ex_mem_o <= ex_mem_d;
        end
    end

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  ex_mem_t ex_mem_i,
    output wb_t     mem_fwd_o,
    output wb_t     wb_o,
    output logic    ram_we_o,
    output word_t   ram_addr_o,
    output word_t   ram_data_o
);

    // full-word stores only, the port always accepts
    assign ram_we_o   = ex_mem_i.is_store;
    assign ram_addr_o = ex_mem_i.mem_addr;
    assign ram_data_o = ex_mem_i.store_data;

    assign mem_fwd_o.we    = ex_mem_i.wreg;
    assign mem_fwd_o.waddr = ex_mem_i.waddr;
    assign mem_fwd_o.wdata = ex_mem_i.wdata;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o.we <= 1'b0;
        end else begin
            wb_o <= mem_fwd_o;
        end
    end

    // decode never marks a store as a register write
    a_store_no_wreg: assert property (@(posedge clk) disable iff (reset_i)
        !(ex_mem_i.is_store && ex_mem_i.wreg));

endmodule

//--- rtl/openmips.sv
`timescale 1ns/1ps

module openmips import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  word_t rom_data_i,
    output word_t rom_addr_o,
    output logic  rom_ce_o,
    output logic  ram_we_o,
    output word_t ram_addr_o,
    output word_t ram_data_o
);

    word_t     if_id_inst;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       ex_fwd;
    wb_t       mem_fwd;
    wb_t       mem_wb;

    fetch_stage u_fetch (
        .clk        (clk),
        .reset_i    (reset_i),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .inst_o     (if_id_inst)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wb_i     (mem_wb)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset_i   (reset_i),
        .inst_i    (if_id_inst),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .raddr1_o  (raddr1),
        .raddr2_o  (raddr2),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .id_ex_o   (id_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset_i  (reset_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .ex_mem_o (ex_mem)
    );

    memory_stage u_memory (
        .clk        (clk),
        .reset_i    (reset_i),
        .ex_mem_i   (ex_mem),
        .mem_fwd_o  (mem_fwd),
        .wb_o       (mem_wb),
        .ram_we_o   (ram_we_o),
        .ram_addr_o (ram_addr_o),
        .ram_data_o (ram_data_o)
    );

endmodule

//--- tests/openmips_tb.sv
`timescale 1ns/1ps

module openmips_tb import mips_pkg::*; ();

    localparam int tail_len  = 12;
    localparam int rom_depth = 128;

    typedef struct packed {
        word_t       addr;
        word_t       data;
        logic [31:0] slot;
    } store_t;

    logic  clk = 1'b0;
    logic  reset_i;
    word_t rom_data_i;
    word_t rom_addr_o;
    logic  rom_ce_o;
    logic  ram_we_o;
    word_t ram_addr_o;
    word_t ram_data_o;

    word_t  rom [rom_depth];
    int     rom_len;
    int     prog_len;
    int     fetch_idx;
    int     cur_cycle;
    int     checked_cycles;
    int     cycle_count;
    int     cycle_limit;
    int     last_slot;
    store_t exp_q[$];
    string  name_q[$];
    store_t head;
    string  head_name;
    int     seed_val;

    openmips u_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .ram_we_o   (ram_we_o),
        .ram_addr_o (ram_addr_o),
        .ram_data_o (ram_data_o)
    );

    always #2 clk = ~clk;

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_store(string name, word_t exp_addr, word_t exp_data,
                               word_t act_addr, word_t act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            fail_run($sformatf("Error: %s expected addr %h data %h, actual addr %h data %h",
                               name, exp_addr, exp_data, act_addr, act_data));
        end
    endtask

    task automatic check_fetch(string name, word_t exp_addr, word_t act_addr);
        if (act_addr !== exp_addr) begin
            fail_run($sformatf("Error: %s expected %h actual %h", name, exp_addr, act_addr));
        end
    endtask

    // words past the loaded image read as zero, which is a no-op
    function automatic word_t rom_word(word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < rom_len) begin
            return rom[idx];
        end
        return '0;
    endfunction

    task automatic load_patterns();
        int     fd;
        int     code;
        string  line;
        string  kind;
        string  name;
        word_t  inst;
        word_t  addr;
        word_t  data;
        store_t st;
        fd = $fopen("tests/program_patterns.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tests/program_patterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            code = $sscanf(line, "%s %h %h %h %s", kind, inst, addr, data, name);
            if (kind == "I" && code >= 2) begin
                rom[rom_len] = inst;
                rom_len = rom_len + 1;
            end else if (kind == "S" && code == 5) begin
                // store leaves the memory port 3 cycles after its fetch
                st.addr = addr;
                st.data = data;
                st.slot = rom_len + 3;
                exp_q.push_back(st);
                name_q.push_back(name);
                rom[rom_len] = inst;
                rom_len = rom_len + 1;
            end else begin
                fail_run({"malformed line in pattern file: ", line});
            end
        end
        $fclose(fd);
    endtask

    // sll with rd = r0, random rt and shamt
    task automatic fill_tail();
        word_t r;
        for (int k = 0; k < tail_len; k++) begin
            r = $urandom;
            rom[rom_len] = {6'b000000, 5'b00000, r[4:0], 5'b00000, r[9:5], 6'b000000};
            rom_len = rom_len + 1;
        end
    endtask

    // the DUT presents this address in the cycle after the edge
    always @(posedge clk) begin
        if (!reset_i) begin
            rom_data_i <= rom_word(word_t'(fetch_idx * 4));
            fetch_idx  <= fetch_idx + 1;
        end
    end

    always @(negedge clk) begin
        if (fetch_idx == 0) begin
            if (rom_ce_o !== 1'b0) begin
                fail_run("rom_ce_o is high before the first fetch cycle");
            end
            if (ram_we_o !== 1'b0) begin
                fail_run("ram_we_o is not low while the core is in reset");
            end
        end else begin
            cur_cycle = fetch_idx - 1;
            if (rom_ce_o !== 1'b1) begin
                fail_run($sformatf("rom_ce_o is not high in fetch cycle %0d", cur_cycle));
            end
            check_fetch($sformatf("fetch_cycle_%0d", cur_cycle), word_t'(cur_cycle * 4),
                        rom_addr_o);
            if (ram_we_o === 1'b1) begin
                if (exp_q.size() == 0) begin
                    fail_run($sformatf("extra store to %h in cycle %0d, none was expected",
                                       ram_addr_o, cur_cycle));
                end
                head = exp_q.pop_front();
                head_name = name_q.pop_front();
                if (int'(head.slot) != cur_cycle) begin
                    fail_run($sformatf("store %s came in cycle %0d instead of cycle %0d",
                                       head_name, cur_cycle, head.slot));
                end
                check_store(head_name, head.addr, head.data, ram_addr_o, ram_data_o);
            end else if (ram_we_o !== 1'b0) begin
                fail_run($sformatf("ram_we_o is unknown in cycle %0d", cur_cycle));
            end else if (exp_q.size() != 0 && int'(exp_q[0].slot) == cur_cycle) begin
                fail_run($sformatf("store %s is missing in cycle %0d", name_q[0], cur_cycle));
            end
            checked_cycles = cur_cycle + 1;
        end
    end

    initial begin
        reset_i        = 1'b1;
        rom_data_i     = '0;
        rom_len        = 0;
        fetch_idx      = 0;
        cur_cycle      = 0;
        checked_cycles = 0;
        cycle_count    = 0;
        seed_val = $urandom(32'he950);

        load_patterns();
        prog_len = rom_len;
        fill_tail();
        // run until the last tail word has passed its store slot
        last_slot   = rom_len - 1 + 3;
        cycle_limit = prog_len + 20;

        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        while (checked_cycles <= last_slot) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                fail_run("timeout: the expected stores did not all appear before the cycle limit");
            end
        end

        if (exp_q.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            fail_run($sformatf("%0d expected stores never appeared", exp_q.size()));
        end
    end

endmodule

//--- tests/program_patterns.txt
# I <instruction word> <assembly>: instruction only
# S <sw word> <address> <data> <name>: store and the write it must produce
I 34018765 ori r1, r0, 0x8765
I 3C02ABCD lui r2, 0xabcd
I 3843F0F0 xori r3, r2, 0xf0f0
I 30648F0F andi r4, r3, 0x8f0f
I 2405FFF0 addiu r5, r0, 0xfff0
S AC010100 00000100 00008765 ori_zext
S AC020104 00000104 ABCD0000 lui_upper
S AC030108 00000108 ABCDF0F0 xori_zext
S AC04010C 0000010C 00008000 andi_zext
S AC050110 00000110 FFFFFFF0 addiu_sext
I 00A13021 addu r6, r5, r1
I 00253823 subu r7, r1, r5
I 00434024 and r8, r2, r3
I 00224825 or r9, r1, r2
I 00655026 xor r10, r3, r5
I 00015900 sll r11, r1, 4
I 00026202 srl r12, r2, 8
S AC060114 00000114 00008755 addu_wrap
S AC070118 00000118 00008775 subu_wrap
S AC08011C 0000011C ABCD0000 and_reg
S AC090120 00000120 ABCD8765 or_reg
S AC0A0124 00000124 54320F00 xor_reg
S AC0B0128 00000128 00087650 sll_shamt
S AC0C012C 0000012C 00ABCD00 srl_shamt
I 240D0011 addiu r13, r0, 0x11
I 01AD7021 addu r14, r13, r13
I 01CD7821 addu r15, r14, r13
I 01ED8023 subu r16, r15, r13
S AC100130 00000130 00000022 fwd_dist_1_2_3
S AC8FFFFC 00007FFC 00000033 fwd_dist3_neg_offset
I 80010000 lb r1, 0(r0)
I 0043082A slt r1, r2, r3
I 34005555 ori r0, r0, 0x5555
S AC000138 00000138 00000000 r0_stays_zero
S AC01013C 0000013C 00008765 unknown_is_nop

//--- tb.f
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/openmips.sv
tests/openmips_tb.sv
